/* list.f */
+incdir+include
design/ddc_pkg.sv
design/tap_if.sv
design/sample_window.sv
design/pulse_analyzer.sv
design/ddc_regs.sv
design/ddc_top.sv
dv/tb_ddc_top.sv

/* dv/tb_ddc_top.sv */
`include "ddc_params.svh"

module tb_ddc_top import ddc_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam sample_t IDLE_CODE     = 14'h0100;   // positive, window stays frozen
    localparam int      FILL_MAG      = 50;         // below threshold on both gains
    localparam int      PULSE_CYCLES  = 2 * 15;     // worst case, with positive gaps
    localparam int      RESULT_CYCLES = 8;          // snapshot write plus three reads
    localparam int      RAND_ROUNDS   = 25;
    localparam int      RAND_LEN      = 120;
    localparam int      MAX_CYCLES    = 3 + 6 * PULSE_CYCLES + 7 * RESULT_CYCLES
                                        + RAND_ROUNDS * (RAND_LEN + RESULT_CYCLES) + 50;

    logic    ADA_DCO = 1'b0;
    logic    hps_fpga_reset_n;
    sample_t ada_d;
    sample_t adb_d;
    logic    psel;
    logic    penable;
    logic    pwrite;
    addr_t   paddr;
    word_t   pwdata;
    word_t   prdata;

    ddc_top dut (.*);

    always #10 ADA_DCO = ~ADA_DCO;  // 20 ns period

    // ======================================================================
    // reference model state, channel 0 = a, 1 = b
    // ======================================================================
    int          win [2][`DDC_WINDOW];  // magnitudes, 0 newest
    int          res_hit [2];           // analyzer outputs
    int          res_peak [2];
    int          res_tail [2];
    int          live_peak [2];
    int          live_tail [2];
    int          shd_peak [2];
    int          shd_tail [2];
    int          live_time;
    int          shd_time;
    int          model_cnt;             // mirrors the time-stamp counter
    int          cycle_count;
    bit          free_run;              // random samples on every cycle
    logic [31:0] rng = 32'h7791_b6c2;
    word_t       got_peak;
    word_t       got_tail;
    word_t       got_time;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic sample_t neg_code(input int mag);
        return sample_t'(`DDC_FULL_SCALE - mag);
    endfunction

    function automatic sample_t positive_code();
        return sample_t'(next_random() % `DDC_NEG_LIMIT);
    endfunction

    // coarse levels so flat tops and saturation show up, optional jitter
    function automatic sample_t random_code();
        logic [31:0] r;
        int          mag;
        r = next_random();
        if (r[31:30] == 2'b00)
            return sample_t'(r[12:0]);
        mag = 1 + int'(r[2:0]) * 1150 + (r[29] ? int'(r[20:16]) : 0);
        return neg_code(mag);
    endfunction

    function automatic word_t pair_word(input int a, input int b);
        return word_t'((b << 16) | a);
    endfunction

    // peak test and tail interpolation on one pre-shift window
    function automatic bit analyze_taps(input int pre_pk, pk, post_pk, pre_t, mid_t, post_t,
                                        input int gain, output int peak_out, output int tail_out);
        int w_rise;
        int w_fall;
        peak_out = 0;
        tail_out = 0;
        if (!(pre_pk <= pk && pk >= post_pk && pk * gain > `DDC_PEAK_THRESHOLD))
            return 1'b0;
        if (pk < `DDC_PEAK_LIMIT)   // saturated pulses report zeros
        begin
            w_rise   = pk - pre_pk;
            w_fall   = pk - post_pk;
            peak_out = pk;
            if (w_rise + w_fall == 0)
                tail_out = mid_t;
            else
                tail_out = (w_rise * post_t + w_fall * pre_t) / (w_rise + w_fall);
        end
        return 1'b1;
    endfunction

    function automatic word_t expected_prdata();
        if (!(psel && penable && !pwrite))
            return '0;
        if (paddr == `DDC_REG_PEAK)
            return pair_word(shd_peak[0], shd_peak[1]);
        if (paddr == `DDC_REG_TAIL)
            return pair_word(shd_tail[0], shd_tail[1]);
        if (paddr == `DDC_REG_TIME)
            return word_t'(shd_time);
        return '0;
    endfunction

    // one rising edge of the model, inputs as sampled by the DUT
    task automatic model_edge();
        int raw [2];
        int pk;
        int tl;
        raw[0] = ada_d;
        raw[1] = adb_d;
        if (psel && penable && pwrite && paddr == `DDC_REG_CTRL)
        begin
            for (int ch = 0; ch < 2; ch++)
            begin
                shd_peak[ch] = live_peak[ch];   // old live values
                shd_tail[ch] = live_tail[ch];
            end
            shd_time = live_time;
        end
        for (int ch = 0; ch < 2; ch++)
        begin
            if (res_hit[ch] != 0)
            begin
                live_peak[ch] = res_peak[ch];
                live_tail[ch] = res_tail[ch];
                if (ch == 1)
                    live_time = model_cnt;  // stamp of the registering edge
            end
            res_hit[ch] = 0;
            if (raw[ch] >= `DDC_NEG_LIMIT)
            begin
                if (analyze_taps(win[ch][13], win[ch][12], win[ch][11], win[ch][2],
                                 win[ch][1], win[ch][0], (ch == 0) ? 1 : `DDC_GAIN_B, pk, tl))
                begin
                    res_hit[ch]  = 1;
                    res_peak[ch] = pk;
                    res_tail[ch] = tl;
                end
                for (int i = `DDC_WINDOW - 1; i > 0; i--)
                    win[ch][i] = win[ch][i-1];
                win[ch][0] = `DDC_FULL_SCALE - raw[ch];
            end
        end
        model_cnt = (model_cnt + 1) % (1 << `DDC_TIME_W);
    endtask

    // ======================================================================
    // checking, failure and timeout
    // ======================================================================
    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_stop($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    always @(negedge ADA_DCO)   // inputs and prdata settled mid-cycle
    begin
        if (hps_fpga_reset_n)
            compare_word("prdata", prdata, expected_prdata());
    end

    always @(posedge ADA_DCO)
    begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES)
            fail_stop($sformatf("timeout: run exceeded %0d cycles", MAX_CYCLES));
    end

    // ======================================================================
    // stimulus
    // ======================================================================
    task automatic tick();
        @(posedge ADA_DCO);
        model_edge();
        #2;
        if (free_run)
        begin
            ada_d = random_code();
            adb_d = random_code();
        end
    endtask

    task automatic apb_write(input addr_t addr);
        psel    = 1'b1;             // setup
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = next_random();    // ignored by ctrl
        tick();
        penable = 1'b1;             // access
        tick();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input addr_t addr, output word_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        tick();
        penable = 1'b1;
        @(negedge ADA_DCO);
        data = prdata;
        tick();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_results(input bit snapshot);
        if (snapshot)
            apb_write(`DDC_REG_CTRL);
        apb_read(`DDC_REG_PEAK, got_peak);
        apb_read(`DDC_REG_TAIL, got_tail);
        apb_read(`DDC_REG_TIME, got_time);
    endtask

    // 15 negative samples, peak at index 1 reaches the peak tap on the last one
    task automatic send_pulse(input bit to_a, input bit to_b, input bit gaps,
                              input int lead, input int pk, input int trail,
                              input int pre_t, input int mid_t, input int post_t);
        int shape [15];
        for (int i = 0; i < 15; i++)
            shape[i] = FILL_MAG;
        shape[0]  = lead;
        shape[1]  = pk;
        shape[2]  = trail;
        shape[11] = pre_t;
        shape[12] = mid_t;
        shape[13] = post_t;
        for (int i = 0; i < 15; i++)
        begin
            ada_d = to_a ? neg_code(shape[i]) : IDLE_CODE;
            adb_d = to_b ? neg_code(shape[i]) : IDLE_CODE;
            tick();
            if (gaps)
            begin
                ada_d = positive_code();    // must not move either window
                adb_d = positive_code();
                tick();
            end
        end
        ada_d = IDLE_CODE;
        adb_d = IDLE_CODE;
    endtask

    initial
    begin
        word_t data;
        hps_fpga_reset_n = 1'b0;
        ada_d            = IDLE_CODE;
        adb_d            = IDLE_CODE;
        psel             = 1'b0;
        penable          = 1'b0;
        pwrite           = 1'b0;
        paddr            = '0;
        pwdata           = '0;
        repeat (3) @(posedge ADA_DCO);
        #2;
        hps_fpga_reset_n = 1'b1;

        // saturated pulse on both channels, only the b time stamp moves
        send_pulse(1, 1, 0, 3000, 8000, 3000, 100, 100, 100);
        read_results(1);
        compare_word("peak", got_peak, pair_word(0, 0));
        compare_word("tail", got_tail, pair_word(0, 0));
        if (got_time == '0)
            fail_stop("saturated pulse on channel b left no time stamp");

        // clean pulse on a, (3000*811 + 2000*400) / 5000
        send_pulse(1, 0, 0, 2000, 5000, 3000, 400, 600, 811);
        read_results(1);
        compare_word("peak", got_peak, pair_word(5000, 0));
        compare_word("tail", got_tail, pair_word(646, 0));

        // peak 300, b only, (200*90 + 100*40) / 300
        send_pulse(1, 1, 0, 100, 300, 200, 40, 70, 90);
        read_results(1);
        compare_word("peak", got_peak, pair_word(5000, 300));
        compare_word("tail", got_tail, pair_word(646, 73));

        // new hits, shadows hold until ctrl write
        send_pulse(1, 0, 0, 3500, 4000, 1000, 300, 500, 700);
        send_pulse(0, 1, 0, 150, 400, 250, 60, 80, 95);
        read_results(0);
        compare_word("peak", got_peak, pair_word(5000, 300));
        compare_word("tail", got_tail, pair_word(646, 73));
        apb_read(`DDC_REG_CTRL, data);
        compare_word("ctrl", data, '0);
        read_results(1);
        compare_word("peak", got_peak, pair_word(4000, 400));
        compare_word("tail", got_tail, pair_word(357, 81));

        // same a pulse as before with positive codes in between
        send_pulse(1, 0, 1, 2000, 5000, 3000, 400, 600, 811);
        read_results(1);
        compare_word("peak", got_peak, pair_word(5000, 400));
        compare_word("tail", got_tail, pair_word(646, 81));

        // random streams, prdata checked against the model on every read
        free_run = 1'b1;
        repeat (RAND_ROUNDS)
        begin
            repeat (RAND_LEN) tick();
            read_results(1);
        end
        free_run = 1'b0;

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule : tb_ddc_top

/* design/ddc_top.sv */
`include "ddc_params.svh"

module ddc_top import ddc_pkg::*;
(
    input  logic    ADA_DCO,            // adc data clock, both channels
    input  logic    hps_fpga_reset_n,

    // adc data
    input  sample_t ada_d,
    input  sample_t adb_d,

    // host register access
    input  logic    psel,
    input  logic    penable,
    input  logic    pwrite,
    input  addr_t   paddr,
    input  word_t   pwdata,
    output word_t   prdata
);

    // ======================================================================
    // channel a
    // ======================================================================
    tap_if tap_a ();

    logic hit_a;
    mag_t peak_a;
    mag_t tail_a;

    sample_window u_win_a
    (
        .clk   (ADA_DCO),
        .rst_n (hps_fpga_reset_n),
        .raw   (ada_d),
        .taps  (tap_a.source)
    );

    pulse_analyzer #(.GAIN(1)) u_ana_a    // unity gain
    (
        .clk      (ADA_DCO),
        .rst_n    (hps_fpga_reset_n),
        .taps     (tap_a.sink),
        .hit      (hit_a),
        .peak_val (peak_a),
        .tail_val (tail_a)
    );

    // ======================================================================
    // channel b
    // ======================================================================
    tap_if tap_b ();

    logic hit_b;
    mag_t peak_b;
    mag_t tail_b;

    sample_window u_win_b
    (
        .clk   (ADA_DCO),               // shares the a clock
        .rst_n (hps_fpga_reset_n),
        .raw   (adb_d),
        .taps  (tap_b.source)
    );

    pulse_analyzer #(.GAIN(`DDC_GAIN_B)) u_ana_b
    (
        .clk      (ADA_DCO),
        .rst_n    (hps_fpga_reset_n),
        .taps     (tap_b.sink),
        .hit      (hit_b),
        .peak_val (peak_b),
        .tail_val (tail_b)
    );

    // results, time stamp and apb
    ddc_regs u_regs
    (
        .clk     (ADA_DCO),
        .rst_n   (hps_fpga_reset_n),
        .hit_a   (hit_a),
        .peak_a  (peak_a),
        .tail_a  (tail_a),
        .hit_b   (hit_b),
        .peak_b  (peak_b),
        .tail_b  (tail_b),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata)
    );

endmodule : ddc_top

/* design/ddc_regs.sv */
`include "ddc_params.svh"

module ddc_regs import ddc_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    // channel a results
    input  logic  hit_a,
    input  mag_t  peak_a,
    input  mag_t  tail_a,

    // channel b results, also time stamped
    input  logic  hit_b,
    input  mag_t  peak_b,
    input  mag_t  tail_b,

    // apb slave, zero wait states
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  addr_t paddr,
    input  word_t pwdata,   // ctrl is a command register, value is don't-care
    output word_t prdata
);

    // two 14-bit channel values packed into one bus word
    function automatic word_t pack_pair(input mag_t lo, input mag_t hi);
        return {2'b00, hi, 2'b00, lo};
    endfunction

    // ======================================================================
    // time-stamp counter
    // ======================================================================
    stamp_t time_cnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            time_cnt <= '0;
        else
            time_cnt <= time_cnt + 1'b1;    // wraps at 2**26
    end

    // ======================================================================
    // live results, follow every hit
    // ======================================================================
    mag_t   live_peak_a, live_tail_a;
    mag_t   live_peak_b, live_tail_b;
    stamp_t live_time;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            live_peak_a <= '0;
            live_tail_a <= '0;
            live_peak_b <= '0;
            live_tail_b <= '0;
            live_time   <= '0;
        end
        else
        begin
            if (hit_a)
            begin
                live_peak_a <= peak_a;
                live_tail_a <= tail_a;
            end
            if (hit_b)
            begin
                live_peak_b <= peak_b;
                live_tail_b <= tail_b;
                live_time   <= time_cnt;    // counter value at this edge
            end
        end
    end

    // ======================================================================
    // snapshot shadows and apb decode
    // ======================================================================
    logic   acc;            // access phase
    logic   snap;
    mag_t   shd_peak_a, shd_tail_a;
    mag_t   shd_peak_b, shd_tail_b;
    stamp_t shd_time;

    assign acc  = psel & penable;
    assign snap = acc & pwrite & (paddr == `DDC_ADDR_W'(`DDC_REG_CTRL));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shd_peak_a <= '0;
            shd_tail_a <= '0;
            shd_peak_b <= '0;
            shd_tail_b <= '0;
            shd_time   <= '0;
        end
        else if (snap)      // a hit on the same edge lands in the next snapshot
        begin
            shd_peak_a <= live_peak_a;
            shd_tail_a <= live_tail_a;
            shd_peak_b <= live_peak_b;
            shd_tail_b <= live_tail_b;
            shd_time   <= live_time;
        end
    end

    // read mux, only drives during a read access
    always_comb
    begin
        prdata = '0;
        if (acc && !pwrite)
        begin
            case (paddr)
                `DDC_ADDR_W'(`DDC_REG_PEAK): prdata = pack_pair(shd_peak_a, shd_peak_b);
                `DDC_ADDR_W'(`DDC_REG_TAIL): prdata = pack_pair(shd_tail_a, shd_tail_b);
                `DDC_ADDR_W'(`DDC_REG_TIME):
                    prdata = {{(`DDC_WORD_W - `DDC_TIME_W){1'b0}}, shd_time};
                default: prdata = '0;   // ctrl and holes read 0
            endcase
        end
    end

endmodule : ddc_regs

/* design/pulse_analyzer.sv */
`include "ddc_params.svh"

module pulse_analyzer import ddc_pkg::*;
#(
    parameter int unsigned GAIN = 1     // detection gain on the peak tap
)
(
    input  logic clk,
    input  logic rst_n,
    tap_if.sink  taps,
    output logic hit,                   // one cycle after the accepting edge
    output mag_t peak_val,
    output mag_t tail_val
);

    // ======================================================================
    // peak test
    // ======================================================================
    logic        rising_ok;             // pre_peak <= peak
    logic        falling_ok;            // peak >= post_peak
    logic [31:0] peak_gain;
    logic        above_thr;
    logic        in_range;              // below saturation
    logic        detect;

    assign rising_ok  = (taps.pre_peak <= taps.peak);
    assign falling_ok = (taps.peak >= taps.post_peak);

    assign peak_gain  = taps.peak * GAIN;   // 32-bit context, no overflow
    assign above_thr  = (peak_gain > `DDC_PEAK_THRESHOLD);
    assign in_range   = (taps.peak < `DDC_PEAK_LIMIT);

    // only evaluated on edges that also shift the window
    assign detect = taps.accept & rising_ok & falling_ok & above_thr;

    // ======================================================================
    // tail interpolation
    // ======================================================================
    // post_tail weighted by the rise, pre_tail by the fall
    // both weights are >= 0 whenever detect is high
    mag_t        w_post;
    mag_t        w_pre;
    logic [28:0] num;                   // two 14x14 products plus carry
    logic [14:0] den;
    logic [28:0] quot;
    mag_t        tail_calc;

    assign w_post = taps.peak - taps.pre_peak;
    assign w_pre  = taps.peak - taps.post_peak;

    // operands widen to 29 bits before the multiply
    assign num = w_post * taps.post_tail + w_pre * taps.pre_tail;
    assign den = w_post + w_pre;

    // flat top, no slope to weight with
    assign quot      = (den == '0) ? 29'(taps.mid_tail) : num / den;
    assign tail_calc = mag_t'(quot);    // mean of two 14-bit taps, fits

    // ======================================================================
    // result registers
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hit      <= 1'b0;
            peak_val <= '0;
            tail_val <= '0;
        end
        else
        begin
            hit <= detect;              // pulses even when saturated
            if (detect)
            begin
                if (in_range)
                begin
                    peak_val <= taps.peak;
                    tail_val <= tail_calc;
                end
                else
                begin
                    // saturated pulse, report zeros
                    peak_val <= '0;
                    tail_val <= '0;
                end
            end
        end
    end

endmodule : pulse_analyzer

/* design/sample_window.sv */
`include "ddc_params.svh"

module sample_window import ddc_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t raw,        // adc code, sampled every cycle
    tap_if.source   taps
);

    // ======================================================================
    // magnitude of the incoming sample
    // ======================================================================
    logic [`DDC_SAMPLE_W:0] mag_full;   // one spare bit for the subtract
    mag_t                   mag_in;
    logic                   neg;

    assign neg      = (raw >= `DDC_NEG_LIMIT);  // upper half of the code range
    assign mag_full = `DDC_FULL_SCALE - raw;
    assign mag_in   = mag_t'(mag_full);         // 8192 .. 1 for negative codes

    // ======================================================================
    // window shift register
    // ======================================================================
    mag_t win [`DDC_WINDOW];    // win[0] newest

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `DDC_WINDOW; i++)
            begin
                win[i] <= '0;
            end
        end
        else if (neg)                   // positive samples leave it frozen
        begin
            win[0] <= mag_in;
            for (int i = 1; i < `DDC_WINDOW; i++)
            begin
                win[i] <= win[i-1];     // age by one entry
            end
        end
    end

    // taps show the window before the shift on this edge
    assign taps.accept    = neg;
    assign taps.pre_peak  = win[`DDC_WINDOW-1];
    assign taps.peak      = win[`DDC_WINDOW-2];
    assign taps.post_peak = win[`DDC_WINDOW-3];

    // tail end of the window
    assign taps.pre_tail  = win[2];
    assign taps.mid_tail  = win[1];
    assign taps.post_tail = win[0];

endmodule : sample_window

/* design/tap_if.sv */
// fixed taps of one channel window, newest entry is 0
interface tap_if import ddc_pkg::*; ();

    logic accept;       // current input sample is negative
    mag_t pre_peak;     // entry 13
    mag_t peak;         // entry 12
    mag_t post_peak;    // entry 11
    mag_t pre_tail;     // entry 2
    mag_t mid_tail;     // entry 1
    mag_t post_tail;    // entry 0

    modport source
    (
        output accept, pre_peak, peak, post_peak,
        output pre_tail, mid_tail, post_tail
    );

    modport sink
    (
        input accept, pre_peak, peak, post_peak,
        input pre_tail, mid_tail, post_tail
    );

endinterface : tap_if

/* design/ddc_pkg.sv */
package ddc_pkg;

    // widths follow the params header
    typedef logic [13:0] sample_t;  // raw adc code in two's complement
    typedef logic [13:0] mag_t;     // magnitude of a negative sample

    typedef logic [25:0] stamp_t;   // free-running time stamp

    // apb side
    typedef logic [31:0] word_t;
    typedef logic [3:0]  addr_t;

endpackage : ddc_pkg

/* include/ddc_params.svh */
`ifndef DDC_PARAMS_SVH
`define DDC_PARAMS_SVH

// ==========================================================================
// datapath widths
// ==========================================================================
`define DDC_SAMPLE_W        14      // adc word
`define DDC_TIME_W          26      // time-stamp counter
`define DDC_WORD_W          32      // apb data bus
`define DDC_ADDR_W          4       // apb byte address

// ==========================================================================
// trigger window and thresholds
// ==========================================================================
`define DDC_WINDOW          14      // entries 0 (newest) .. 13 (oldest)
`define DDC_NEG_LIMIT       8192    // codes at or above are negative samples
`define DDC_FULL_SCALE      16384   // magnitude = full scale - raw code
`define DDC_PEAK_THRESHOLD  2760    // gained peak must exceed this
`define DDC_PEAK_LIMIT      8000    // saturation, results forced to zero
`define DDC_GAIN_B          12      // channel b detection gain

// ==========================================================================
// register map
// ==========================================================================
`define DDC_REG_PEAK        'h0
`define DDC_REG_TAIL        'h4
`define DDC_REG_TIME        'h8
`define DDC_REG_CTRL        'hC     // write = snapshot, read = 0

`endif
